// ==== flist.f ====
+incdir+source
source/board_pkg.sv
source/tm_serial_if.sv
source/digit_capture.sv
source/tm_bit_timer.sv
source/tm_byte_shifter.sv
source/tm_sequencer.sv
source/board_top.sv
sim/board_top_properties.sv
sim/tb_board_top.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_board_top -o tb_board_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_board_top)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "test passed"; then
    exit 0
fi
exit 1

// ==== sim/tb_board_top.sv ====
`timescale 1ns/1ps

`include "board_macros.svh"

`default_nettype none

module tb_board_top;

    localparam int CLK_PERIOD   = 40;
    localparam int FRAME_BYTES  = 3 + 2 * `TM_DIGITS;      // 0x40, 0xC0, data, 0x8F
    localparam int BYTE_CYCLES  = 16 * `TM_HALF_BIT + 4;   // Bits plus load and done
    localparam int FRAME_CYCLES = `TM_REFRESH + FRAME_BYTES * BYTE_CYCLES
                                + 3 * (`TM_HALF_BIT + 2);
    localparam int NUM_TESTS    = 4;
    localparam int TIMEOUT_NS   = 4 * NUM_TESTS * FRAME_CYCLES * CLK_PERIOD;

    logic                    clk = 1'b0;
    logic                    rst;
    board_pkg::seg_t         abcdefgh;
    board_pkg::digit_sel_t   digit;
    logic [`TM_DIGITS - 1:0] led;
    board_pkg::seg_t         hex_out [`HEX_DIGITS];
    logic                    sio_stb;
    logic                    sio_clk;
    logic                    sio_data;

    board_pkg::seg_t hex_model   [`HEX_DIGITS];      // Expected static displays
    board_pkg::seg_t frame_model [`TM_DIGITS];       // Expected frame buffer
    logic [15:0]     lfsr = 16'd58;
    int              n_checks = 0;
    int              n_errors = 0;

    logic [7:0] rx_bytes [$];                        // Decoded serial bytes
    int         rx_groups [$];                       // Strobe group of each byte
    logic [7:0] rx_shift = '0;
    int         rx_count = 0;
    int         rx_group = -1;

    always #(CLK_PERIOD / 2) clk = ~clk;

    board_top i_board_top
    (
        .clk      ( clk        ),
        .rst      ( rst        ),
        .abcdefgh ( abcdefgh   ),
        .digit    ( digit      ),
        .led      ( led        ),
        .hex0     ( hex_out[0] ),
        .hex1     ( hex_out[1] ),
        .hex2     ( hex_out[2] ),
        .hex3     ( hex_out[3] ),
        .hex4     ( hex_out[4] ),
        .hex5     ( hex_out[5] ),
        .sio_stb  ( sio_stb    ),
        .sio_clk  ( sio_clk    ),
        .sio_data ( sio_data   )
    );

    bind board_top board_top_properties i_board_top_properties
    (
        .clk      ( clk          ),
        .rst      ( rst          ),
        .sio_stb  ( sio_stb      ),
        .sio_clk  ( sio_clk      ),
        .sio_data ( sio_data     ),
        .load     ( tm_bus.load  ),
        .busy     ( tm_bus.busy  )
    );

    // ------------------------------
    // Serial decoder
    // ------------------------------

    always @(posedge sio_clk)
    begin
        if (sio_stb === 1'b0)
        begin
            rx_shift = {sio_data, rx_shift[7:1]};    // LSB arrives first
            rx_count = rx_count + 1;
            if (rx_count == 8)
            begin
                rx_bytes.push_back(rx_shift);
                rx_groups.push_back(rx_group);
                rx_count = 0;
            end
        end
    end

    always @(negedge sio_stb)
    begin
        rx_group = rx_group + 1;                     // New strobe group
    end

    // ------------------------------
    // Helpers
    // ------------------------------

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic lsb;
        lsb = s[0];
        s   = s >> 1;
        if (lsb)
            s = s ^ 16'hB400;                        // x^16 + x^14 + x^13 + x^11 + 1
        return s;
    endfunction

    task automatic random_byte(output logic [7:0] value);
        value = '0;
        for (int i = 0; i < 8; i++)
        begin
            lfsr  = lfsr_step(lfsr);                 // One step per bit
            value = {value[6:0], lfsr[0]};
        end
    endtask

    function automatic logic [7:0] reverse_bits(input logic [7:0] v);
        logic [7:0] r;
        for (int i = 0; i < 8; i++)
            r[i] = v[7 - i];
        return r;
    endfunction

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] want);
        n_checks++;
        if (got !== want)
        begin
            n_errors++;
            $display("Error: %s = %h, expected %h", name, got, want);
        end
    endtask

    task automatic check_hex();
        for (int n = 0; n < `HEX_DIGITS; n++)
            check_value($sformatf("hex%0d", n), hex_out[n], hex_model[n]);
    endtask

    // Select one digit for a single cycle
    task automatic write_digit(input int n, input logic [7:0] pattern);
        @(posedge clk);
        abcdefgh <= pattern;
        digit    <= board_pkg::digit_sel_t'(1) << n;
        @(posedge clk);
        digit    <= '0;
        if (n < `HEX_DIGITS)
            hex_model[n] = ~reverse_bits(pattern);  // Active low, hgfedcba
        frame_model[n] = reverse_bits(pattern);
        @(negedge clk);
    endtask

    // ------------------------------
    // Tests
    // ------------------------------

    task automatic check_reset();
        for (int n = 0; n < `HEX_DIGITS; n++)
            hex_model[n] = 8'hFF;
        for (int n = 0; n < `TM_DIGITS; n++)
            frame_model[n] = 8'h00;
        @(negedge clk);
        check_hex();
        check_value("sio_stb", {7'b0, sio_stb}, 8'h01);
        check_value("sio_clk", {7'b0, sio_clk}, 8'h01);
        check_value("sio_data", {7'b0, sio_data}, 8'h00);
    endtask

    task automatic check_static_displays();
        logic [7:0] pattern;
        random_byte(pattern);
        @(posedge clk);
        led <= pattern;
        for (int n = 0; n < `TM_DIGITS - 1; n++)     // Digit 7 stays unwritten
        begin
            random_byte(pattern);
            write_digit(n, pattern);
            check_hex();                             // Earlier displays are sticky
        end
    endtask

    task automatic check_frame(input int frame_no);
        logic [7:0] got;
        logic [7:0] want;
        int         grp_got;
        int         grp_want;
        int         base;
        int         i;
        while (rx_bytes.size() < FRAME_BYTES)
            @(posedge clk);
        base = rx_groups[0];
        n_checks++;
        if (base % 3 != 0)
        begin
            n_errors++;
            $display("Frame %0d does not begin with a command group", frame_no);
        end
        for (int k = 0; k < FRAME_BYTES; k++)
        begin
            got     = rx_bytes.pop_front();
            grp_got = rx_groups.pop_front();
            i       = (k - 2) / 2;                   // Digit of a data byte
            if (k == 0)
            begin
                want     = 8'h40;
                grp_want = base;
            end
            else if (k == 1)
            begin
                want     = 8'hC0;
                grp_want = base + 1;
            end
            else if (k == FRAME_BYTES - 1)
            begin
                want     = 8'h8F;
                grp_want = base + 2;
            end
            else
            begin
                want     = (k % 2 == 0) ? frame_model[i] : {7'b0, led[i]};
                grp_want = base + 1;
            end
            check_value($sformatf("sio_data byte %0d of frame %0d", k, frame_no), got, want);
            n_checks++;
            if (grp_got != grp_want)
            begin
                n_errors++;
                $display("Byte %0d of frame %0d was sent in the wrong strobe group",
                         k, frame_no);
            end
        end
    endtask

    task automatic check_frame_update();
        logic [7:0] pattern;
        random_byte(pattern);
        @(posedge clk);
        led <= pattern;
        random_byte(pattern);
        write_digit(7, pattern);
        random_byte(pattern);
        write_digit(2, pattern);
        check_hex();
        check_frame(2);                              // No input needed for the refresh
    endtask

    initial
    begin
        #(TIMEOUT_NS);
        $display("Timeout: the serial frames did not arrive in time");
        $display("test failed");
        $finish;
    end

    initial
    begin
        rst      = 1'b1;
        abcdefgh = '0;
        digit    = '0;
        led      = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        check_reset();
        check_static_displays();
        check_frame(1);
        check_frame_update();
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/board_top_properties.sv ====
`timescale 1ns/1ps

`default_nettype none

module board_top_properties
(
    input logic clk,
    input logic rst,
    input logic sio_stb,
    input logic sio_clk,
    input logic sio_data,
    input logic load,       // Sequencer byte request
    input logic busy        // Shifter at work
);

    // ------------------------------
    // Serial link rules
    // ------------------------------

    // Covers the rising edge of sio_clk too
    data_stable_clk_high : assert property (@(posedge clk) disable iff (rst)
        sio_clk |-> $stable(sio_data))
        else $error("sio_data changed while sio_clk was high");

    clk_high_stb_high : assert property (@(posedge clk) disable iff (rst)
        sio_stb |-> sio_clk)                   // Idle bus between groups
        else $error("sio_clk low while sio_stb is high");

    // Shifter cannot take a second byte
    no_load_when_busy : assert property (@(posedge clk) disable iff (rst)
        load |-> !busy)
        else $error("load raised while the shifter was busy");

endmodule

`default_nettype wire

// ==== source/board_top.sv ====
`timescale 1ns/1ps

`include "board_macros.svh"

`default_nettype none

module board_top
(
    input  logic                    clk,
    input  logic                    rst,
    input  board_pkg::seg_t         abcdefgh,  // Lab core segment bus
    input  board_pkg::digit_sel_t   digit,
    input  logic [`TM_DIGITS - 1:0] led,       // TM1638 LEDs
    output board_pkg::seg_t         hex0,
    output board_pkg::seg_t         hex1,
    output board_pkg::seg_t         hex2,
    output board_pkg::seg_t         hex3,
    output board_pkg::seg_t         hex4,
    output board_pkg::seg_t         hex5,
    output logic                    sio_stb,   // TM1638 STB
    output logic                    sio_clk,   // TM1638 CLK
    output logic                    sio_data   // TM1638 DIO, write only
);

    logic                  frame_start;
    logic                  frame_idle;
    board_pkg::digit_idx_t rd_idx;
    board_pkg::seg_t       rd_seg;

    tm_serial_if tm_bus ();                     // Sequencer, shifter and timer link

    // ------------------------------
    // Digit storage
    // ------------------------------

    digit_capture i_digit_capture
    (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    ),
        .rd_idx   ( rd_idx   ),
        .hex0     ( hex0     ),
        .hex1     ( hex1     ),
        .hex2     ( hex2     ),
        .hex3     ( hex3     ),
        .hex4     ( hex4     ),
        .hex5     ( hex5     ),
        .rd_seg   ( rd_seg   )
    );

    // ------------------------------
    // TM1638 refresh
    // ------------------------------

    tm_bit_timer i_tm_bit_timer
    (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .frame_idle  ( frame_idle  ),
        .frame_start ( frame_start ),
        .tm          ( tm_bus      )
    );

    tm_byte_shifter i_tm_byte_shifter
    (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .sio_clk  ( sio_clk  ),
        .sio_data ( sio_data ),
        .tm       ( tm_bus   )
    );

    tm_sequencer i_tm_sequencer
    (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .frame_start ( frame_start ),
        .rd_seg      ( rd_seg      ),
        .led         ( led         ),
        .frame_idle  ( frame_idle  ),
        .rd_idx      ( rd_idx      ),
        .sio_stb     ( sio_stb     ),
        .tm          ( tm_bus      )
    );

endmodule

`default_nettype wire

// ==== source/tm_sequencer.sv ====
`timescale 1ns/1ps

`include "board_macros.svh"

`default_nettype none

module tm_sequencer
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    frame_start,
    input  board_pkg::seg_t         rd_seg,      // Segment byte of digit rd_idx
    input  logic [`TM_DIGITS - 1:0] led,
    output logic                    frame_idle,
    output board_pkg::digit_idx_t   rd_idx,
    output logic                    sio_stb,     // Active low strobe
    tm_serial_if.sequencer          tm
);

    localparam board_pkg::seg_t CMD_WRITE = 8'h40;  // Write display, auto increment
    localparam board_pkg::seg_t CMD_ADDR0 = 8'hC0;  // Start at address 0
    localparam board_pkg::seg_t CMD_DISP  = 8'h8F;  // Display on, brightness 7
    localparam int DATA_BYTES = 2 * `TM_DIGITS;     // Segment and LED byte per digit
    localparam int GAP_W      = $clog2(`TM_HALF_BIT + 1);

    board_pkg::tm_state_t state;
    logic [4:0]           byte_cnt;   // Data bytes finished in this frame
    logic [GAP_W - 1:0]   gap_cnt;    // Strobe high time between groups
    logic                 issued;     // Byte of this step already loaded
    logic                 send_now;
    logic                 gap_end;

    assign send_now   = !issued && !tm.busy;
    assign gap_end    = (gap_cnt == GAP_W'(`TM_HALF_BIT - 1));
    assign frame_idle = (state == board_pkg::IDLE);
    assign rd_idx     = board_pkg::digit_idx_t'(byte_cnt >> 1);  // Ready before the load

    // ------------------------------
    // Byte selection
    // ------------------------------

    always_comb
    begin
        case (state)
            board_pkg::CMD_MODE: tm.byte_data = CMD_WRITE;
            board_pkg::ADDR:     tm.byte_data = CMD_ADDR0;
            board_pkg::CTRL:     tm.byte_data = CMD_DISP;
            board_pkg::DATA:     tm.byte_data = byte_cnt[0]
                                     ? board_pkg::seg_t'(led[rd_idx])  // LED on bit 0
                                     : rd_seg;
            default:             tm.byte_data = '0;
        endcase
    end

    // ------------------------------
    // Frame FSM
    // ------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state    <= board_pkg::IDLE;
            byte_cnt <= '0;
            gap_cnt  <= '0;
            issued   <= 1'b0;
            sio_stb  <= 1'b1;
            tm.load  <= 1'b0;
        end
        else
        begin
            tm.load <= 1'b0;                    // Pulse
            case (state)
                board_pkg::IDLE:
                    if (frame_start)
                    begin
                        state   <= board_pkg::CMD_MODE;
                        sio_stb <= 1'b0;        // Open group 1
                    end
                board_pkg::CMD_MODE, board_pkg::CTRL:
                    if (tm.done)
                    begin
                        state   <= (state == board_pkg::CTRL) ? board_pkg::GAP3
                                                              : board_pkg::GAP1;
                        sio_stb <= 1'b1;        // Close the one-byte group
                        gap_cnt <= '0;
                        issued  <= 1'b0;
                    end
                    else if (send_now)
                    begin
                        tm.load <= 1'b1;
                        issued  <= 1'b1;
                    end
                board_pkg::ADDR:
                    if (tm.done)
                    begin
                        state    <= board_pkg::DATA;  // Strobe stays low
                        byte_cnt <= '0;
                        issued   <= 1'b0;
                    end
                    else if (send_now)
                    begin
                        tm.load <= 1'b1;
                        issued  <= 1'b1;
                    end
                board_pkg::DATA:
                    if (byte_cnt == 5'(DATA_BYTES))
                    begin
                        state   <= board_pkg::GAP2;
                        sio_stb <= 1'b1;
                        gap_cnt <= '0;
                    end
                    else if (tm.done)
                    begin
                        byte_cnt <= byte_cnt + 1'b1;
                        issued   <= 1'b0;
                    end
                    else if (send_now)
                    begin
                        tm.load <= 1'b1;
                        issued  <= 1'b1;
                    end
                default:                        // GAP1, GAP2, GAP3
                    if (gap_end)
                    begin
                        gap_cnt <= '0;
                        case (state)
                            board_pkg::GAP1: state <= board_pkg::ADDR;
                            board_pkg::GAP2: state <= board_pkg::CTRL;
                            default:         state <= board_pkg::IDLE;
                        endcase
                        sio_stb <= (state == board_pkg::GAP3);  // Low for the next group
                    end
                    else
                        gap_cnt <= gap_cnt + 1'b1;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/tm_byte_shifter.sv ====
`timescale 1ns/1ps

`default_nettype none

module tm_byte_shifter
(
    input  logic          clk,
    input  logic          rst,
    output logic          sio_clk,   // Idles high, data taken on rising edge
    output logic          sio_data,
    tm_serial_if.shifter  tm
);

    localparam int BITS  = $bits(board_pkg::seg_t);
    localparam int BIT_W = $clog2(BITS);

    board_pkg::seg_t      shreg;     // Remaining bits, next on bit 1
    logic [BIT_W - 1:0]   bit_cnt;   // Bit now on the line
    logic                 last_bit;
    logic                 next_bit;  // High half over, move to the next bit

    assign last_bit = (bit_cnt == BIT_W'(BITS - 1));
    assign next_bit = tm.busy && tm.tick && sio_clk && !last_bit;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            tm.busy  <= 1'b0;
            tm.done  <= 1'b0;
            sio_clk  <= 1'b1;
            sio_data <= 1'b0;
            bit_cnt  <= '0;
        end
        else
        begin
            tm.done <= 1'b0;                    // Pulse
            if (!tm.busy)
            begin
                if (tm.load)
                begin
                    tm.busy  <= 1'b1;
                    sio_clk  <= 1'b0;           // Low half of bit 0
                    sio_data <= tm.byte_data[0];  // LSB first
                    bit_cnt  <= '0;
                end
            end
            else if (tm.tick)
            begin
                if (!sio_clk)
                    sio_clk <= 1'b1;            // Rising edge, TM1638 samples
                else if (last_bit)
                begin
                    tm.busy <= 1'b0;            // Clock stays high after the byte
                    tm.done <= 1'b1;
                end
                else
                begin
                    sio_clk  <= 1'b0;
                    sio_data <= shreg[1];       // Change data with the clock low
                    bit_cnt  <= bit_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!tm.busy && tm.load)
            shreg <= tm.byte_data;
        else if (next_bit)
            shreg <= shreg >> 1;
    end

endmodule

`default_nettype wire

// ==== source/tm_bit_timer.sv ====
`timescale 1ns/1ps

`include "board_macros.svh"

`default_nettype none

module tm_bit_timer
(
    input  logic          clk,
    input  logic          rst,
    input  logic          frame_idle,   // Sequencer waits in IDLE
    output logic          frame_start,  // Begin the next refresh frame
    tm_serial_if.timer    tm
);

    localparam int HALF_W = $clog2(`TM_HALF_BIT + 1);
    localparam int REF_W  = $clog2(`TM_REFRESH + 1);

    logic [HALF_W - 1:0] half_cnt;      // Clocks into the current half bit
    logic [REF_W  - 1:0] ref_cnt;       // Idle clocks since the last frame

    // ------------------------------
    // Half-bit ticks
    // ------------------------------

    assign tm.tick = tm.busy && (half_cnt == HALF_W'(`TM_HALF_BIT - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            half_cnt <= '0;
        else if (!tm.busy || tm.tick)
            half_cnt <= '0;                     // Restart at each load and each half
        else
            half_cnt <= half_cnt + 1'b1;
    end

    // ------------------------------
    // Refresh interval
    // ------------------------------

    assign frame_start = frame_idle && (ref_cnt == REF_W'(`TM_REFRESH - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            ref_cnt <= '0;
        else if (!frame_idle || frame_start)
            ref_cnt <= '0;                      // Held while a frame is sent
        else
            ref_cnt <= ref_cnt + 1'b1;
    end

endmodule

`default_nettype wire

// ==== source/digit_capture.sv ====
`timescale 1ns/1ps

`include "board_macros.svh"

`default_nettype none

module digit_capture
(
    input  logic                    clk,
    input  logic                    rst,
    input  board_pkg::seg_t         abcdefgh,  // Shared segment bus from the lab core
    input  board_pkg::digit_sel_t   digit,     // Active digit, one-hot
    input  board_pkg::digit_idx_t   rd_idx,    // Frame buffer read address
    output board_pkg::seg_t         hex0,
    output board_pkg::seg_t         hex1,
    output board_pkg::seg_t         hex2,
    output board_pkg::seg_t         hex3,
    output board_pkg::seg_t         hex4,
    output board_pkg::seg_t         hex5,
    output board_pkg::seg_t         rd_seg     // One cycle after rd_idx
);

    board_pkg::seg_t hgfedcba;                  // Segment a on bit 0
    board_pkg::seg_t hex_q   [`HEX_DIGITS];     // Sticky static displays
    board_pkg::seg_t frame_q [`TM_DIGITS];      // TM1638 digit buffer

    // ------------------------------
    // Bit order swap
    // ------------------------------

    for (genvar i = 0; i < $bits(board_pkg::seg_t); i++)
    begin : g_rev
        assign hgfedcba[i] = abcdefgh[$bits(board_pkg::seg_t) - 1 - i];
    end

    // ------------------------------
    // Static displays, active low
    // ------------------------------

    for (genvar n = 0; n < `HEX_DIGITS; n++)
    begin : g_hex
        always_ff @(posedge clk or posedge rst)
        begin
            if (rst)
                hex_q[n] <= '1;                 // Blank
            else if (digit[n])
                hex_q[n] <= ~hgfedcba;          // Hold until digit n is selected again
        end
    end

    assign hex0 = hex_q[0];
    assign hex1 = hex_q[1];
    assign hex2 = hex_q[2];
    assign hex3 = hex_q[3];
    assign hex4 = hex_q[4];
    assign hex5 = hex_q[5];

    // Frame buffer, active high as the TM1638 expects it
    for (genvar n = 0; n < `TM_DIGITS; n++)
    begin : g_frame
        always_ff @(posedge clk or posedge rst)
        begin
            if (rst)
                frame_q[n] <= '0;
            else if (digit[n])
                frame_q[n] <= hgfedcba;
        end
    end

    always_ff @(posedge clk)
    begin
        rd_seg <= frame_q[rd_idx];              // Registered read port
    end

endmodule

`default_nettype wire

// ==== source/tm_serial_if.sv ====
`timescale 1ns/1ps

`default_nettype none

interface tm_serial_if;

    logic                load;       // Start one byte
    board_pkg::seg_t     byte_data;  // Byte to send, valid with load
    logic                busy;       // Byte shift in progress
    logic                done;       // Last bit has finished
    logic                tick;       // Half-bit step

    modport sequencer
    (
        output load,
        output byte_data,
        input  busy,
        input  done
    );

    modport shifter
    (
        input  load,
        input  byte_data,
        input  tick,
        output busy,
        output done
    );

    modport timer
    (
        input  busy,
        output tick
    );

endinterface

`default_nettype wire

// ==== source/board_pkg.sv ====
`include "board_macros.svh"

`default_nettype none

package board_pkg;

    typedef logic [7:0]                       seg_t;        // Segment pattern
    typedef logic [`TM_DIGITS - 1:0]          digit_sel_t;  // One-hot digit select
    typedef logic [$clog2(`TM_DIGITS) - 1:0]  digit_idx_t;  // Digit number

    // Refresh frame sequencer
    typedef enum logic [2:0]
    {
        IDLE,      // Waiting for the refresh interval
        CMD_MODE,  // Data command, auto address increment
        GAP1,      // Strobe high between groups
        ADDR,      // Address command, digit 0
        DATA,      // Segment and LED bytes
        GAP2,
        CTRL,      // Display control, on, full brightness
        GAP3
    } tm_state_t;

endpackage

`default_nettype wire

// ==== source/board_macros.svh ====
`ifndef BOARD_MACROS_SVH
`define BOARD_MACROS_SVH

`default_nettype none

// ------------------------------
// TM1638 serial link timing
// ------------------------------

`define TM_HALF_BIT  4    // Clocks per half period of sio_clk
`define TM_REFRESH   64   // Idle clocks between two frames

// ------------------------------
// Display sizes
// ------------------------------

`define TM_DIGITS    8    // TM1638 digits, also digit select and LED width
`define HEX_DIGITS   6    // Static on-board displays

`default_nettype wire

`endif
